/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and address width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* rvIsaPkg.sv */
package rvIsaPkg;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011
    } opcodeE;

    // ALU functions, add first so a cleared bundle means add
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10
    } aluOpE;

    // Kind of control transfer resolved in execute
    typedef enum logic [1:0] {
        brNone = 2'd0,
        brCond = 2'd1,
        brJal  = 2'd2,
        brJalr = 2'd3
    } branchE;

endpackage

/* pipePkg.sv */
`include "rv_consts.svh"

package pipePkg;

    // ID/EX payload
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1Data;
        logic [`XLEN-1:0]       rs2Data;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rs1Addr;
        logic [`REG_ADDR_W-1:0] rs2Addr;
        logic [`REG_ADDR_W-1:0] rdAddr;
        logic [2:0]             funct3;
    } idExeDataT;

    // ID/EX control, cleared on flush
    typedef struct packed {
        rvIsaPkg::aluOpE  aluOp;
        logic             aluSrcImm;
        logic             pcToReg;
        logic             auipc;
        logic             memToReg;
        logic             memWrite;
        logic             memRead;
        logic             regWrite;
        rvIsaPkg::branchE branch;
    } idExeCtrlT;

    // EX/MEM payload
    typedef struct packed {
        logic [`XLEN-1:0]       aluResult;
        logic [`XLEN-1:0]       storeData;
        logic [`REG_ADDR_W-1:0] rdAddr;
        logic [2:0]             funct3;
    } exeMemDataT;

    typedef struct packed {
        logic memToReg;
        logic memWrite;
        logic memRead;
        logic regWrite;
    } exeMemCtrlT;

    // Register write coming back from writeback
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } wbPortT;

    // Redirect request towards fetch
    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirectT;

endpackage

/* instrDecoder.sv */
`include "rv_consts.svh"

module instrDecoder (
    input  logic [`XLEN-1:0]       instr,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`REG_ADDR_W-1:0] rdAddr,
    output logic [2:0]             funct3,
    output logic [`XLEN-1:0]       imm,
    output pipePkg::idExeCtrlT     ctrl
);

    rvIsaPkg::opcodeE opcode;
    logic [6:0]       funct7;

    // Shared by OP and OP-IMM, sub only exists in the register form
    function automatic rvIsaPkg::aluOpE aluFromFunct(
        input logic [2:0] f3,
        input logic       alt,
        input logic       regForm
    );
        case (f3)
            3'b000:  return (regForm && alt) ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
            3'b001:  return rvIsaPkg::aluSll;
            3'b010:  return rvIsaPkg::aluSlt;
            3'b011:  return rvIsaPkg::aluSltu;
            3'b100:  return rvIsaPkg::aluXor;
            3'b101:  return alt ? rvIsaPkg::aluSra : rvIsaPkg::aluSrl;
            3'b110:  return rvIsaPkg::aluOr;
            default: return rvIsaPkg::aluAnd;
        endcase
    endfunction

    assign opcode  = rvIsaPkg::opcodeE'(instr[6:0]);
    assign funct7  = instr[31:25];
    assign funct3  = instr[14:12];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign rdAddr  = instr[11:7];

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            rvIsaPkg::opOp: begin
                ctrl.aluOp    = aluFromFunct(funct3, funct7[5], 1'b1);
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::opImm: begin
                ctrl.aluOp     = aluFromFunct(funct3, funct7[5], 1'b0);
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            rvIsaPkg::opLui: begin
                ctrl.aluOp     = rvIsaPkg::aluPassB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                imm            = {instr[31:12], 12'b0};
            end
            rvIsaPkg::opAuipc: begin
                ctrl.auipc     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                imm            = {instr[31:12], 12'b0};
            end
            rvIsaPkg::opJal: begin
                ctrl.branch   = rvIsaPkg::brJal;
                ctrl.pcToReg  = 1'b1;
                ctrl.regWrite = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            rvIsaPkg::opJalr: begin
                ctrl.branch   = rvIsaPkg::brJalr;
                ctrl.pcToReg  = 1'b1;
                ctrl.regWrite = 1'b1;
                imm           = {{20{instr[31]}}, instr[31:20]};
            end
            rvIsaPkg::opBranch: begin
                ctrl.branch = rvIsaPkg::brCond;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            rvIsaPkg::opLoad: begin
                // Address only, the data side lives in MEM
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.regWrite  = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            rvIsaPkg::opStore: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* registerFile.sv */
`include "rv_consts.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data,
    input  pipePkg::wbPortT        wb
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            // x0 never written, so it stays zero
            regs[wb.addr] <= wb.data;
        end
    end

    // Asynchronous reads, same-cycle writes come through forwarding
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

/* forwardUnit.sv */
`include "rv_consts.svh"

module forwardUnit (
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`XLEN-1:0]       rfRs1Data,
    input  logic [`XLEN-1:0]       rfRs2Data,
    input  pipePkg::exeMemDataT    exeMemData,
    input  pipePkg::exeMemCtrlT    exeMemCtrl,
    input  pipePkg::wbPortT        wb,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data
);

    logic exeValid;
    logic wbValid;

    // Youngest producer wins, x0 always reads zero
    function automatic logic [`XLEN-1:0] pickOperand(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rfData
    );
        if (addr == '0) return '0;
        if (exeValid && exeMemData.rdAddr == addr) return exeMemData.aluResult;
        if (wbValid && wb.addr == addr) return wb.data;
        return rfData;
    endfunction

    // Load data is not ready in EX/MEM yet
    assign exeValid = exeMemCtrl.regWrite && !exeMemCtrl.memRead;
    assign wbValid  = wb.en;

    always_comb begin
        rs1Data = pickOperand(rs1Addr, rfRs1Data);
        rs2Data = pickOperand(rs2Addr, rfRs2Data);
    end

endmodule

/* pipeStageReg.sv */
module pipeStageReg #(
    parameter type dataT = logic [31:0],
    parameter type ctrlT = logic [7:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flush,
    input  dataT dataIn,
    input  ctrlT ctrlIn,
    output dataT dataOut,
    output ctrlT ctrlOut
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dataOut <= '0;
            ctrlOut <= '0;
        end else if (stall) begin
            // Memory stall freezes the whole stage
            dataOut <= dataOut;
            ctrlOut <= ctrlOut;
        end else if (flush) begin
            // Payload still moves, the bubble comes from the cleared controls
            dataOut <= dataIn;
            ctrlOut <= '0;
        end else begin
            dataOut <= dataIn;
            ctrlOut <= ctrlIn;
        end
    end

endmodule

/* exeUnit.sv */
`include "rv_consts.svh"

module exeUnit (
    input  pipePkg::idExeDataT  data,
    input  pipePkg::idExeCtrlT  ctrl,
    output pipePkg::exeMemDataT outData,
    output pipePkg::exeMemCtrlT outCtrl,
    output pipePkg::redirectT   redirect
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;
    logic             condTrue;

    assign opA = ctrl.auipc ? data.pc : data.rs1Data;
    assign opB = ctrl.aluSrcImm ? data.imm : data.rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            rvIsaPkg::aluAdd:   aluOut = opA + opB;
            rvIsaPkg::aluSub:   aluOut = opA - opB;
            rvIsaPkg::aluSll:   aluOut = opA << opB[4:0];
            rvIsaPkg::aluSlt:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
            rvIsaPkg::aluSltu:  aluOut = {31'b0, opA < opB};
            rvIsaPkg::aluXor:   aluOut = opA ^ opB;
            rvIsaPkg::aluSrl:   aluOut = opA >> opB[4:0];
            rvIsaPkg::aluSra:   aluOut = $signed(opA) >>> opB[4:0];
            rvIsaPkg::aluOr:    aluOut = opA | opB;
            rvIsaPkg::aluAnd:   aluOut = opA & opB;
            rvIsaPkg::aluPassB: aluOut = opB;
            default:            aluOut = '0;
        endcase
    end

    // Branch compare always on the register operands
    always_comb begin
        case (data.funct3)
            3'b000:  condTrue = data.rs1Data == data.rs2Data;
            3'b001:  condTrue = data.rs1Data != data.rs2Data;
            3'b100:  condTrue = $signed(data.rs1Data) < $signed(data.rs2Data);
            3'b101:  condTrue = $signed(data.rs1Data) >= $signed(data.rs2Data);
            3'b110:  condTrue = data.rs1Data < data.rs2Data;
            3'b111:  condTrue = data.rs1Data >= data.rs2Data;
            default: condTrue = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.branch)
            rvIsaPkg::brCond: redirect.taken = condTrue;
            rvIsaPkg::brJal:  redirect.taken = 1'b1;
            rvIsaPkg::brJalr: redirect.taken = 1'b1;
            default:          redirect.taken = 1'b0;
        endcase
        if (ctrl.branch == rvIsaPkg::brJalr) begin
            redirect.target = (data.rs1Data + data.imm) & ~`XLEN'd1;
        end else begin
            redirect.target = data.pc + data.imm;
        end
    end

    // Link value for jumps replaces the ALU result
    assign outData.aluResult = ctrl.pcToReg ? data.pc + `XLEN'd4 : aluOut;
    assign outData.storeData = data.rs2Data;
    assign outData.rdAddr    = data.rdAddr;
    assign outData.funct3    = data.funct3;

    assign outCtrl.memToReg = ctrl.memToReg;
    assign outCtrl.memWrite = ctrl.memWrite;
    assign outCtrl.memRead  = ctrl.memRead;
    assign outCtrl.regWrite = ctrl.regWrite;

endmodule

/* idExeCore.sv */
`include "rv_consts.svh"

module idExeCore (
    input  logic                clk,
    input  logic                reset,
    input  logic [`XLEN-1:0]    instr,
    input  logic [`XLEN-1:0]    pc,
    input  logic                imStall,
    input  logic                dmStall,
    input  pipePkg::wbPortT     wb,
    output pipePkg::exeMemDataT exeMemData,
    output pipePkg::exeMemCtrlT exeMemCtrl,
    output pipePkg::redirectT   redirect
);

    logic                   stall;
    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`XLEN-1:0]       rfRs1Data;
    logic [`XLEN-1:0]       rfRs2Data;

    pipePkg::idExeDataT  idData;
    pipePkg::idExeCtrlT  idCtrl;
    pipePkg::idExeDataT  exeData;
    pipePkg::idExeCtrlT  exeCtrl;
    pipePkg::exeMemDataT exeOutData;
    pipePkg::exeMemCtrlT exeOutCtrl;

    assign stall      = imStall | dmStall;
    assign idData.pc  = pc;
    assign idData.rs1Addr = rs1Addr;
    assign idData.rs2Addr = rs2Addr;

    instrDecoder decoder (
        .instr   (instr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (idData.rdAddr),
        .funct3  (idData.funct3),
        .imm     (idData.imm),
        .ctrl    (idCtrl)
    );

    registerFile regFile (
        .clk     (clk),
        .reset   (reset),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rfRs1Data),
        .rs2Data (rfRs2Data),
        .wb      (wb)
    );

    forwardUnit fwd (
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rfRs1Data  (rfRs1Data),
        .rfRs2Data  (rfRs2Data),
        .exeMemData (exeMemData),
        .exeMemCtrl (exeMemCtrl),
        .wb         (wb),
        .rs1Data    (idData.rs1Data),
        .rs2Data    (idData.rs2Data)
    );

    // Taken branch or jump in EXE squashes the instruction behind it
    pipeStageReg #(
        .dataT (pipePkg::idExeDataT),
        .ctrlT (pipePkg::idExeCtrlT)
    ) idExe (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .flush   (redirect.taken),
        .dataIn  (idData),
        .ctrlIn  (idCtrl),
        .dataOut (exeData),
        .ctrlOut (exeCtrl)
    );

    exeUnit exe (
        .data     (exeData),
        .ctrl     (exeCtrl),
        .outData  (exeOutData),
        .outCtrl  (exeOutCtrl),
        .redirect (redirect)
    );

    pipeStageReg #(
        .dataT (pipePkg::exeMemDataT),
        .ctrlT (pipePkg::exeMemCtrlT)
    ) exeMem (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .flush   (1'b0),
        .dataIn  (exeOutData),
        .ctrlIn  (exeOutCtrl),
        .dataOut (exeMemData),
        .ctrlOut (exeMemCtrl)
    );

endmodule

/* idExeCore_assertions.sv */
`include "rv_consts.svh"

module idExeCoreAssertions (
    input logic                clk,
    input logic                reset,
    input logic [`XLEN-1:0]    instr,
    input logic [`XLEN-1:0]    pc,
    input logic                imStall,
    input logic                dmStall,
    input pipePkg::wbPortT     wb,
    input pipePkg::exeMemDataT exeMemData,
    input pipePkg::exeMemCtrlT exeMemCtrl,
    input pipePkg::redirectT   redirect
);

    // One issued instruction with the operand values it saw in decode
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
    } slotT;

    logic [`XLEN-1:0]    shadow [`REG_COUNT];
    slotT                exeSlot;
    slotT                memSlot;
    logic [`XLEN-1:0]    expResult;
    logic [`XLEN-1:0]    expTarget;
    logic                expTaken;
    logic                checkResult;
    pipePkg::exeMemCtrlT expCtrl;
    int                  errCount = 0;

    function automatic logic [`XLEN-1:0] immOf(input logic [`XLEN-1:0] w);
        case (w[6:0])
            rvIsaPkg::opLui, rvIsaPkg::opAuipc: return {w[31:12], 12'b0};
            rvIsaPkg::opJal:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            rvIsaPkg::opBranch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rvIsaPkg::opStore:  return {{21{w[31]}}, w[30:25], w[11:7]};
            default:            return {{21{w[31]}}, w[30:20]};
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] resultRef(input slotT s);
        logic [`XLEN-1:0] y;
        logic [`XLEN-1:0] r;
        logic [4:0]       sh;
        y  = (s.instr[6:0] == rvIsaPkg::opOp) ? s.b : immOf(s.instr);
        sh = y[4:0];
        case (s.instr[6:0])
            rvIsaPkg::opLui:                     return y;
            rvIsaPkg::opAuipc:                   return s.pc + y;
            rvIsaPkg::opJal, rvIsaPkg::opJalr:   return s.pc + 32'd4;
            rvIsaPkg::opLoad, rvIsaPkg::opStore: return s.a + y;
            default: begin
            end
        endcase
        // OP and OP-IMM, instr[5] marks the register form
        case (s.instr[14:12])
            3'd0: r = (s.instr[5] && s.instr[30]) ? s.a - y : s.a + y;
            3'd1: r = s.a << sh;
            3'd2: r = {31'b0, $signed(s.a) < $signed(y)};
            3'd3: r = {31'b0, s.a < y};
            3'd4: r = s.a ^ y;
            3'd5: begin
                if (s.instr[30]) begin
                    r = $signed(s.a) >>> sh;
                end else begin
                    r = s.a >> sh;
                end
            end
            3'd6: r = s.a | y;
            default: r = s.a & y;
        endcase
        return r;
    endfunction

    // Only the nine supported opcodes are ever issued
    function automatic pipePkg::exeMemCtrlT ctrlRef(input slotT s);
        pipePkg::exeMemCtrlT c;
        c = '0;
        if (s.valid) begin
            c.memRead  = s.instr[6:0] == rvIsaPkg::opLoad;
            c.memToReg = c.memRead;
            c.memWrite = s.instr[6:0] == rvIsaPkg::opStore;
            c.regWrite = !(c.memWrite || s.instr[6:0] == rvIsaPkg::opBranch);
        end
        return c;
    endfunction

    function automatic logic takenRef(input slotT s);
        if (!s.valid) return 1'b0;
        if (s.instr[6:0] == rvIsaPkg::opJal || s.instr[6:0] == rvIsaPkg::opJalr) return 1'b1;
        if (s.instr[6:0] != rvIsaPkg::opBranch) return 1'b0;
        case (s.instr[14:12])
            3'd0:    return s.a == s.b;
            3'd1:    return s.a != s.b;
            3'd4:    return $signed(s.a) < $signed(s.b);
            3'd5:    return $signed(s.a) >= $signed(s.b);
            3'd6:    return s.a < s.b;
            3'd7:    return s.a >= s.b;
            default: return 1'b0;
        endcase
    endfunction

    // Newest value of a register as seen from decode
    function automatic logic [`XLEN-1:0] youngest(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) return '0;
        if (expCtrl.regWrite && !expCtrl.memRead && memSlot.instr[11:7] == addr) begin
            return expResult;
        end
        if (wb.en && wb.addr == addr) return wb.data;
        return shadow[addr];
    endfunction

    always_comb begin
        expResult   = resultRef(memSlot);
        expCtrl     = ctrlRef(memSlot);
        checkResult = memSlot.valid && memSlot.instr[6:0] != rvIsaPkg::opBranch;
        expTaken    = takenRef(exeSlot);
        if (exeSlot.instr[6:0] == rvIsaPkg::opJalr) begin
            expTarget = (exeSlot.a + immOf(exeSlot.instr)) & ~32'd1;
        end else begin
            expTarget = exeSlot.pc + immOf(exeSlot.instr);
        end
    end

    // Two-deep instruction queue, moves only on unstalled edges
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
            exeSlot <= '0;
            memSlot <= '0;
        end else begin
            if (wb.en && wb.addr != '0) begin
                shadow[wb.addr] <= wb.data;
            end
            if (!(imStall || dmStall)) begin
                // A taken branch in EXE kills the entering instruction
                exeSlot <= '{valid: !expTaken, instr: instr, pc: pc,
                             a: youngest(instr[19:15]), b: youngest(instr[24:20])};
                memSlot <= exeSlot;
            end
        end
    end

    resetQuiet: assert property (@(posedge clk)
        reset |-> (exeMemCtrl == '0 && !redirect.taken))
        else begin
            $error("[ERROR] %0t exeMemCtrl/redirect.taken got %b/%b expected 0/0",
                   $time, $sampled(exeMemCtrl), $sampled(redirect.taken));
            errCount++;
        end

    aluResultOk: assert property (@(posedge clk) disable iff (reset)
        checkResult |-> exeMemData.aluResult == expResult)
        else begin
            $error("[ERROR] %0t exeMemData.aluResult got %h expected %h",
                   $time, $sampled(exeMemData.aluResult), $sampled(expResult));
            errCount++;
        end

    rdAddrOk: assert property (@(posedge clk) disable iff (reset)
        memSlot.valid |-> exeMemData.rdAddr == memSlot.instr[11:7])
        else begin
            $error("[ERROR] %0t exeMemData.rdAddr got %0d expected %0d",
                   $time, $sampled(exeMemData.rdAddr), $sampled(memSlot.instr[11:7]));
            errCount++;
        end

    // Store data is the rs2 operand as forwarded in decode
    storeDataOk: assert property (@(posedge clk) disable iff (reset)
        (memSlot.valid && memSlot.instr[6:0] == rvIsaPkg::opStore)
            |-> exeMemData.storeData == memSlot.b)
        else begin
            $error("[ERROR] %0t exeMemData.storeData got %h expected %h",
                   $time, $sampled(exeMemData.storeData), $sampled(memSlot.b));
            errCount++;
        end

    funct3Ok: assert property (@(posedge clk) disable iff (reset)
        memSlot.valid |-> exeMemData.funct3 == memSlot.instr[14:12])
        else begin
            $error("[ERROR] %0t exeMemData.funct3 got %0d expected %0d",
                   $time, $sampled(exeMemData.funct3), $sampled(memSlot.instr[14:12]));
            errCount++;
        end

    ctrlOk: assert property (@(posedge clk) disable iff (reset) exeMemCtrl == expCtrl)
        else begin
            $error("[ERROR] %0t exeMemCtrl got %b expected %b",
                   $time, $sampled(exeMemCtrl), $sampled(expCtrl));
            errCount++;
        end

    takenOk: assert property (@(posedge clk) disable iff (reset) redirect.taken == expTaken)
        else begin
            $error("[ERROR] %0t redirect.taken got %b expected %b",
                   $time, $sampled(redirect.taken), $sampled(expTaken));
            errCount++;
        end

    targetOk: assert property (@(posedge clk) disable iff (reset)
        expTaken |-> redirect.target == expTarget)
        else begin
            $error("[ERROR] %0t redirect.target got %h expected %h",
                   $time, $sampled(redirect.target), $sampled(expTarget));
            errCount++;
        end

    stallHolds: assert property (@(posedge clk) disable iff (reset)
        (imStall || dmStall) |=> $stable(exeMemData) && $stable(exeMemCtrl)
                                 && $stable(redirect))
        else begin
            $error("[ERROR] %0t EX/MEM outputs or redirect changed while stalled", $time);
            errCount++;
        end

endmodule

/* tb_idExeCore.sv */
`include "rv_consts.svh"

module tb_idExeCore;

    localparam int RESET_CYCLES = 10;
    localparam int REG_LOADS    = 7;
    localparam int SPACED_COUNT = 40;
    localparam int DENSE_COUNT  = 60;
    localparam int STALL_COUNT  = 60;
    // Spaced issues take two cycles, stalled ones about two on average
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + REG_LOADS + 2 * SPACED_COUNT
                                         + DENSE_COUNT + 2 * STALL_COUNT + 10);

    logic                clk;
    logic                reset;
    logic [`XLEN-1:0]    instr;
    logic [`XLEN-1:0]    pc;
    logic                imStall;
    logic                dmStall;
    pipePkg::wbPortT     wb;
    pipePkg::exeMemDataT exeMemData;
    pipePkg::exeMemCtrlT exeMemCtrl;
    pipePkg::redirectT   redirect;
    logic [31:0]         seed;
    int                  cycleCount = 0;

    // Index order: OP, OP-IMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE
    rvIsaPkg::opcodeE kinds [9] = '{rvIsaPkg::opOp, rvIsaPkg::opImm, rvIsaPkg::opLui,
                                    rvIsaPkg::opAuipc, rvIsaPkg::opJal, rvIsaPkg::opJalr,
                                    rvIsaPkg::opBranch, rvIsaPkg::opLoad,
                                    rvIsaPkg::opStore};

    idExeCore uut (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc         (pc),
        .imStall    (imStall),
        .dmStall    (dmStall),
        .wb         (wb),
        .exeMemData (exeMemData),
        .exeMemCtrl (exeMemCtrl),
        .redirect   (redirect)
    );

    bind idExeCore idExeCoreAssertions chk (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc         (pc),
        .imStall    (imStall),
        .dmStall    (dmStall),
        .wb         (wb),
        .exeMemData (exeMemData),
        .exeMemCtrl (exeMemCtrl),
        .redirect   (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Random instruction from the first kindCount entries of kinds
    function automatic logic [`XLEN-1:0] randInstr(input int kindCount);
        logic [31:0] w;
        logic [31:0] pick;
        int          kind;
        pick = lcgNext();
        kind = pick[31:16] % kindCount;
        w    = lcgNext();
        // Registers limited to x0..x7 so dependencies show up often
        w[24:23] = 2'b00;
        w[19:18] = 2'b00;
        w[11:10] = 2'b00;
        w[6:0]   = kinds[kind];
        if (kind == 0 || (kind == 1 && w[13:12] == 2'b01)) begin
            w[31:25] = {1'b0, w[30], 5'b0};
        end
        if (kind == 5) begin
            w[14:12] = 3'b000;
        end
        if (kind >= 7) begin
            w[14:12] = 3'b010;
        end
        return w;
    endfunction

    // Present one instruction until an unstalled edge has taken it
    task automatic issue(input logic [`XLEN-1:0] word, input bit randomWb,
                         input bit randomStall);
        logic [31:0] r;
        instr = word;
        do begin
            r       = lcgNext();
            imStall = randomStall && r[31:30] == 2'b00;
            dmStall = randomStall && r[29:28] == 2'b00;
            wb.en   = randomWb && r[27];
            wb.addr = {2'b00, r[18:16]};
            wb.data = lcgNext();
            @(negedge clk);
        end while (imStall || dmStall);
        pc = pc + 32'd4;
    endtask

    initial begin
        seed    = 32'd95;
        reset   = 1'b1;
        instr   = `NOP_INSTR;
        pc      = '0;
        imStall = 1'b0;
        dmStall = 1'b0;
        wb      = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // Random operands into x1..x7
        for (int i = 1; i <= REG_LOADS; i++) begin
            wb.en   = 1'b1;
            wb.addr = i[`REG_ADDR_W-1:0];
            wb.data = lcgNext();
            @(negedge clk);
        end
        wb.en = 1'b0;
        repeat (SPACED_COUNT) begin
            issue(randInstr(4), 1'b0, 1'b0);
            issue(`NOP_INSTR, 1'b0, 1'b0);
        end
        // Back-to-back stream, writebacks land in the decode cycle
        repeat (DENSE_COUNT) issue(randInstr(9), 1'b1, 1'b0);
        repeat (STALL_COUNT) issue(randInstr(9), 1'b1, 1'b1);
        repeat (4) issue(`NOP_INSTR, 1'b0, 1'b0);
        if (uut.chk.errCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion errors were reported");
        end
    end

    // Stop at the first assertion failure
    always @(negedge clk) begin
        if (uut.chk.errCount != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "an assertion in the idExeCore checker failed");
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout after %0d cycles", cycleCount);
        end
    end

endmodule

/* all.f */
+incdir+.
rvIsaPkg.sv
pipePkg.sv
instrDecoder.sv
registerFile.sv
forwardUnit.sv
pipeStageReg.sv
exeUnit.sv
idExeCore.sv
idExeCore_assertions.sv
tb_idExeCore.sv

/* Bender.yml */
package:
  name: id_exe_core

export_include_dirs:
  - .

sources:
  - rvIsaPkg.sv
  - pipePkg.sv
  - instrDecoder.sv
  - registerFile.sv
  - forwardUnit.sv
  - pipeStageReg.sv
  - exeUnit.sv
  - idExeCore.sv
  - target: test
    files:
      - idExeCore_assertions.sv
      - tb_idExeCore.sv
